// ==== hw/mmio_pkg.sv ====
package mmio_pkg;

    localparam int XLEN = 64;

    // Data RAM window
    localparam logic [XLEN-1:0] RAM_BASE  = 64'h0000_0000_8000_0000;
    localparam int              RAM_WORDS = 512;                 // Double-words
    localparam logic [XLEN-1:0] RAM_LEN   = 64'(RAM_WORDS * 8);  // Bytes
    localparam int              RAM_AW    = $clog2(RAM_WORDS * 8); // Byte offset width

    // Peripheral windows of PERI_LEN bytes each
    localparam logic [XLEN-1:0] KBD_ADDR = 64'h0000_0000_a000_0060;
    localparam logic [XLEN-1:0] SWT_ADDR = 64'h0000_0000_a000_0070;
    localparam logic [XLEN-1:0] RTC_ADDR = 64'h0000_0000_a000_0048;
    localparam logic [XLEN-1:0] SEG_ADDR = 64'h0000_0000_a000_0080;
    localparam logic [XLEN-1:0] LED_ADDR = 64'h0000_0000_a000_0090;
    localparam logic [XLEN-1:0] PERI_LEN = 64'd8;

    // Keyboard scan-code FIFO
    localparam int KB_WIDTH = 8;
    localparam int KB_DEPTH = 8;
    localparam int KB_PTR_W = $clog2(KB_DEPTH);
    localparam int KB_CNT_W = KB_PTR_W + 1;     // Holds 0..KB_DEPTH

    localparam int SEG_WIDTH = 32;
    localparam int LED_WIDTH = 16;

    // Real-time counter prescaler
    localparam int RTC_DIV = 4;                 // Clock cycles per tick
    localparam int RTC_PW  = $clog2(RTC_DIV);

    // Access width with zero extension on loads for the U kinds
    typedef enum logic [2:0] {
        W_B  = 3'd0,
        W_H  = 3'd1,
        W_W  = 3'd2,
        W_D  = 3'd3,
        W_BU = 3'd4,
        W_HU = 3'd5,
        W_WU = 3'd6
    } mem_width_e;

    // One load port and one store port per cycle
    typedef struct packed {
        logic                ren;
        logic [XLEN-1:0]     raddr;
        mem_width_e          rwidth;
        logic                wen;
        logic [XLEN-1:0]     waddr;
        logic [XLEN-1:0]     wdata;
        mem_width_e          wwidth;
    } mem_req_t;

    // Address falls inside [base, base + len)
    function automatic logic in_window(input logic [XLEN-1:0] addr,
                                       input logic [XLEN-1:0] base,
                                       input logic [XLEN-1:0] len);
        return (addr >= base) && (addr < base + len);
    endfunction

endpackage

// ==== hw/data_ram.sv ====
`timescale 1ns/100ps

module data_ram (
    input  logic                            clk,
    input  logic                            ren,
    input  logic                            wen,
    input  logic [mmio_pkg::RAM_AW-1:0]     raddr,   // Byte offset from RAM base
    input  logic [mmio_pkg::RAM_AW-1:0]     waddr,
    input  logic [mmio_pkg::XLEN-1:0]       wdata,
    input  mmio_pkg::mem_width_e            rwidth,
    input  mmio_pkg::mem_width_e            wwidth,
    output logic [mmio_pkg::XLEN-1:0]       rdata
);

    import mmio_pkg::*;

    logic [XLEN-1:0] mem [RAM_WORDS];

    logic [RAM_AW-4:0] widx;
    logic [2:0]        woff;
    logic [7:0]        wmask;
    logic [XLEN-1:0]   wdata_sh;

    logic [RAM_AW-4:0] ridx;
    logic [2:0]        roff;
    logic [XLEN-1:0]   field;

    // Byte lanes touched by a store of the given size at lane offset off
    function automatic logic [7:0] lane_mask(input mem_width_e w, input logic [2:0] off);
        logic [7:0] base;
        case (w)
            W_B, W_BU: base = 8'h01;
            W_H, W_HU: base = 8'h03;
            W_W, W_WU: base = 8'h0f;
            default:   base = 8'hff;
        endcase
        return base << off;
    endfunction

    assign widx     = waddr[RAM_AW-1:3];
    assign woff     = waddr[2:0];
    assign wmask    = lane_mask(wwidth, woff);
    assign wdata_sh = wdata << {woff, 3'b000};  // Move data onto its lanes

    always_ff @(posedge clk) begin
        if (wen) begin
            for (int i = 0; i < 8; i++) begin
                if (wmask[i]) begin
                    mem[widx][i*8 +: 8] <= wdata_sh[i*8 +: 8];
                end
            end
        end
    end

    assign ridx  = raddr[RAM_AW-1:3];
    assign roff  = raddr[2:0];
    assign field = mem[ridx] >> {roff, 3'b000};  // Addressed field in low bits

    always_comb begin
        rdata = '0;
        if (ren) begin
            case (rwidth)
                W_B:  rdata = {{(XLEN-8){field[7]}}, field[7:0]};
                W_H:  rdata = {{(XLEN-16){field[15]}}, field[15:0]};
                W_W:  rdata = {{(XLEN-32){field[31]}}, field[31:0]};
                W_D:  rdata = field;
                W_BU: rdata = {{(XLEN-8){1'b0}}, field[7:0]};
                W_HU: rdata = {{(XLEN-16){1'b0}}, field[15:0]};
                W_WU: rdata = {{(XLEN-32){1'b0}}, field[31:0]};
                default: rdata = '0;    // Unused encoding
            endcase
        end
    end

endmodule

// ==== hw/kbd_fifo.sv ====
`timescale 1ns/100ps

module kbd_fifo (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [mmio_pkg::KB_WIDTH-1:0]   kb_code,
    input  logic                            kb_valid,   // One strobe per scan code
    input  logic                            pop,
    output logic                            ready,
    output logic [mmio_pkg::KB_WIDTH-1:0]   head
);

    import mmio_pkg::*;

    logic [KB_WIDTH-1:0] fifo_mem [KB_DEPTH];
    logic [KB_PTR_W-1:0] rd_ptr;
    logic [KB_PTR_W-1:0] wr_ptr;
    logic [KB_CNT_W-1:0] count;
    logic                do_push;
    logic                do_pop;

    assign do_pop  = pop && (count != '0);
    // A full FIFO still accepts a code when the head leaves this cycle
    assign do_push = kb_valid && ((count != KB_CNT_W'(KB_DEPTH)) || do_pop);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;        // Wraps at KB_DEPTH
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            fifo_mem[wr_ptr] <= kb_code;
        end
    end

    assign ready = (count != '0);
    assign head  = fifo_mem[rd_ptr];

endmodule

// ==== hw/rtc_timer.sv ====
`timescale 1ns/100ps

module rtc_timer (
    input  logic                        clk,
    input  logic                        rst_n,
    output logic [mmio_pkg::XLEN-1:0]   count
);

    import mmio_pkg::*;

    logic [RTC_PW-1:0] presc;
    logic              wrap;

    assign wrap = (presc == RTC_PW'(RTC_DIV - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            presc <= '0;
            count <= '0;
        end else begin
            if (wrap) begin
                presc <= '0;
                count <= count + 1'b1;  // One tick per RTC_DIV edges
            end else begin
                presc <= presc + 1'b1;
            end
        end
    end

endmodule

// ==== hw/mmio.sv ====
`timescale 1ns/100ps

module mmio (
    input  logic                            clk,
    input  logic                            rst_n,
    input  mmio_pkg::mem_req_t              req,
    input  logic [mmio_pkg::XLEN-1:0]       ram_rdata,   // Already extended
    input  logic                            kb_ready,
    input  logic [mmio_pkg::KB_WIDTH-1:0]   kb_head,
    input  logic [7:0]                      swt,
    input  logic [mmio_pkg::XLEN-1:0]       rtc_count,
    output logic                            ram_ren,
    output logic                            ram_wen,
    output logic [mmio_pkg::RAM_AW-1:0]     ram_raddr,
    output logic [mmio_pkg::RAM_AW-1:0]     ram_waddr,
    output logic [mmio_pkg::XLEN-1:0]       rdata,
    output logic                            kb_pop,
    output logic [mmio_pkg::SEG_WIDTH-1:0]  seg,
    output logic [mmio_pkg::LED_WIDTH-1:0]  led
);

    import mmio_pkg::*;

    logic            rd_ram;
    logic            rd_kbd;
    logic            rd_swt;
    logic            rd_rtc;
    logic            wr_ram;
    logic            wr_seg;
    logic            wr_led;
    logic [XLEN-1:0] raddr_off;
    logic [XLEN-1:0] waddr_off;

    // Read-side window hits
    assign rd_ram = in_window(req.raddr, RAM_BASE, RAM_LEN);
    assign rd_kbd = in_window(req.raddr, KBD_ADDR, PERI_LEN);
    assign rd_swt = in_window(req.raddr, SWT_ADDR, PERI_LEN);
    assign rd_rtc = in_window(req.raddr, RTC_ADDR, PERI_LEN);

    // Write-side window hits
    assign wr_ram = in_window(req.waddr, RAM_BASE, RAM_LEN);
    assign wr_seg = in_window(req.waddr, SEG_ADDR, PERI_LEN);
    assign wr_led = in_window(req.waddr, LED_ADDR, PERI_LEN);

    assign raddr_off = req.raddr - RAM_BASE;
    assign waddr_off = req.waddr - RAM_BASE;
    assign ram_raddr = raddr_off[RAM_AW-1:0];   // Byte offset into RAM
    assign ram_waddr = waddr_off[RAM_AW-1:0];

    assign ram_ren = req.ren && rd_ram;
    assign ram_wen = req.wen && wr_ram;         // Stores outside RAM never reach it

    always_comb begin
        rdata  = '0;
        kb_pop = 1'b0;
        if (req.ren) begin
            if (rd_ram) begin
                rdata = ram_rdata;
            end else if (rd_kbd) begin
                if (kb_ready) begin
                    kb_pop = 1'b1;              // Head drops at next edge
                    rdata  = XLEN'(kb_head);
                end
            end else if (rd_swt) begin
                rdata = XLEN'(swt);
            end else if (rd_rtc) begin
                rdata = rtc_count;
            end
        end
    end

    // Display registers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seg <= '0;
            led <= '0;
        end else if (req.wen) begin
            if (wr_seg) begin
                seg <= req.wdata[SEG_WIDTH-1:0];
            end else if (wr_led) begin
                led <= req.wdata[LED_WIDTH-1:0];
            end
        end
    end

endmodule

// ==== hw/mmio_top.sv ====
`timescale 1ns/100ps

module mmio_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  mmio_pkg::mem_req_t              req,
    input  logic [7:0]                      kb_code,
    input  logic                            kb_valid,
    input  logic [7:0]                      swt,
    output logic [mmio_pkg::XLEN-1:0]       rdata,
    output logic [mmio_pkg::SEG_WIDTH-1:0]  seg,
    output logic [mmio_pkg::LED_WIDTH-1:0]  led
);

    import mmio_pkg::*;

    logic                ram_ren;
    logic                ram_wen;
    logic [RAM_AW-1:0]   ram_raddr;
    logic [RAM_AW-1:0]   ram_waddr;
    logic [XLEN-1:0]     ram_rdata;
    logic                kb_ready;
    logic [KB_WIDTH-1:0] kb_head;
    logic                kb_pop;
    logic [XLEN-1:0]     rtc_count;

    mmio u_mmio (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .ram_rdata (ram_rdata),
        .kb_ready  (kb_ready),
        .kb_head   (kb_head),
        .swt       (swt),
        .rtc_count (rtc_count),
        .ram_ren   (ram_ren),
        .ram_wen   (ram_wen),
        .ram_raddr (ram_raddr),
        .ram_waddr (ram_waddr),
        .rdata     (rdata),
        .kb_pop    (kb_pop),
        .seg       (seg),
        .led       (led)
    );

    data_ram u_ram (
        .clk    (clk),
        .ren    (ram_ren),
        .wen    (ram_wen),
        .raddr  (ram_raddr),
        .waddr  (ram_waddr),
        .wdata  (req.wdata),
        .rwidth (req.rwidth),
        .wwidth (req.wwidth),
        .rdata  (ram_rdata)
    );

    kbd_fifo u_kbd (
        .clk      (clk),
        .rst_n    (rst_n),
        .kb_code  (kb_code),
        .kb_valid (kb_valid),
        .pop      (kb_pop),
        .ready    (kb_ready),
        .head     (kb_head)
    );

    rtc_timer u_rtc (
        .clk   (clk),
        .rst_n (rst_n),
        .count (rtc_count)
    );

endmodule

// ==== tests/mmio_sva.sv ====
`timescale 1ns/100ps

module mmio_sva (
    input logic                           clk,
    input logic                           rst_n,
    input mmio_pkg::mem_req_t             req,
    input logic                           kb_pop,
    input logic                           kb_ready,
    input logic [mmio_pkg::SEG_WIDTH-1:0] seg,
    input logic [mmio_pkg::LED_WIDTH-1:0] led,
    input logic [mmio_pkg::XLEN-1:0]      rtc_count
);

    import mmio_pkg::*;

    logic kbd_read;

    assign kbd_read = req.ren && (req.raddr >= KBD_ADDR) && (req.raddr < KBD_ADDR + PERI_LEN);

    pop_needs_read: assert property (@(posedge clk) kb_pop |-> (kb_ready && kbd_read))
        else $error("kb_pop raised without a keyboard read of a non-empty FIFO");

    // One reset edge clears the display registers
    regs_clear_in_reset: assert property (@(posedge clk) !rst_n |=> (seg == '0 && led == '0))
        else $error("seg or led not cleared by reset");

    rtc_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> (rtc_count >= $past(rtc_count)))
        else $error("rtc_count decreased outside reset");

endmodule

bind mmio_top mmio_sva u_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .kb_pop    (kb_pop),
    .kb_ready  (kb_ready),
    .seg       (seg),
    .led       (led),
    .rtc_count (rtc_count)
);

// ==== tests/tb_mmio.sv ====
`timescale 1ns/100ps

module tb_mmio;

    import mmio_pkg::*;

    localparam int N_RAM      = 400;
    localparam int N_DISP     = 150;
    localparam int N_KBD      = 200;
    localparam int N_SWT      = 60;
    localparam int N_RTC      = 40;
    // Prefill, random phases, RTC gaps up to 4 cycles, RAM readback, bursts, drains and resets
    localparam int TOTAL_CYC  = RAM_WORDS + N_RAM + N_DISP + N_KBD + N_SWT + 4 * N_RTC + 80;
    localparam int TIMEOUT_NS = TOTAL_CYC * 4 + 400;

    localparam logic [63:0] UNMAPPED [8] = '{
        64'h0, 64'ha000_0050, 64'ha000_0068, 64'ha000_0058,
        SEG_ADDR, LED_ADDR, RAM_BASE + RAM_LEN, 64'h7fff_fff8
    };

    logic                 clk;
    logic                 rst_n;
    mem_req_t             req;
    logic [7:0]           kb_code;
    logic                 kb_valid;
    logic [7:0]           swt;
    logic [XLEN-1:0]      rdata;
    logic [SEG_WIDTH-1:0] seg;
    logic [LED_WIDTH-1:0] led;

    logic [15:0]          lfsr;
    logic [63:0]          ram_m [RAM_WORDS];
    logic [7:0]           kb_q [$];
    logic [SEG_WIDTH-1:0] seg_m;
    logic [LED_WIDTH-1:0] led_m;
    logic [63:0]          edges;       // Rising edges since reset release
    int                   checks;
    int                   errors;

    mmio_top uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .kb_code  (kb_code),
        .kb_valid (kb_valid),
        .swt      (swt),
        .rdata    (rdata),
        .seg      (seg),
        .led      (led)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            edges <= '0;
        end else begin
            edges <= edges + 64'd1;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[62:0], fb};
        end
        return r;
    endfunction

    function automatic mem_width_e pick_width();
        logic [2:0] r;
        r = 3'(rand_bits(3));
        if (r == 3'd7) begin
            r = 3'd3;                   // Fold the unused code onto W_D
        end
        return mem_width_e'(r);
    endfunction

    function automatic int width_bytes(input mem_width_e w);
        case (w)
            W_B, W_BU: return 1;
            W_H, W_HU: return 2;
            W_W, W_WU: return 4;
            default:   return 8;
        endcase
    endfunction

    task automatic store_model(input logic [8:0] idx, input logic [2:0] off,
                               input mem_width_e w, input logic [63:0] data);
        logic [63:0] mask;
        mask       = {64{1'b1}} >> (64 - 8 * width_bytes(w));
        ram_m[idx] = (ram_m[idx] & ~(mask << {off, 3'b000}))
                   | ((data & mask) << {off, 3'b000});
    endtask

    function automatic logic [63:0] load_model(input logic [8:0] idx, input logic [2:0] off,
                                               input mem_width_e w);
        logic [63:0] v;
        int          sh;
        sh = 64 - 8 * width_bytes(w);
        v  = (ram_m[idx] >> {off, 3'b000}) << sh;   // Field's top bit at bit 63
        if (w == W_B || w == W_H || w == W_W) begin
            return $signed(v) >>> sh;
        end
        return v >> sh;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH %s at %0t: got 0x%h, expected 0x%h", name, $time, got, exp);
        end
    endtask

    task automatic start_cycle();
        @(negedge clk);
        check_value("seg", 64'(seg), 64'(seg_m));
        check_value("led", 64'(led), 64'(led_m));
        req      = '0;
        kb_valid = 1'b0;
    endtask

    task automatic issue_read(input logic [63:0] addr, input mem_width_e w);
        req.ren    = 1'b1;
        req.raddr  = addr;
        req.rwidth = w;
        #1;                             // Combinational rdata settles
    endtask

    task automatic ram_op();
        mem_width_e  w;
        logic [8:0]  idx;
        logic [2:0]  off;
        logic [63:0] data;
        start_cycle();
        w   = pick_width();
        idx = 9'(rand_bits(9));
        off = 3'(rand_bits(3)) & ~3'(width_bytes(w) - 1);   // Aligned to the size
        if (rand_bits(1) == 64'd1) begin
            data       = rand_bits(64);
            req.wen    = 1'b1;
            req.waddr  = RAM_BASE + {52'd0, idx, off};
            req.wdata  = data;
            req.wwidth = w;
            store_model(idx, off, w, data);
        end else begin
            issue_read(RAM_BASE + {52'd0, idx, off}, w);
            check_value("rdata", rdata, load_model(idx, off, w));
        end
    endtask

    task automatic disp_write(input logic [63:0] addr, input logic [63:0] data);
        start_cycle();
        req.wen    = 1'b1;
        req.waddr  = addr;
        req.wdata  = data;
        req.wwidth = pick_width();
        if (addr[63:3] == SEG_ADDR[63:3]) begin
            seg_m = data[SEG_WIDTH-1:0];
        end
        if (addr[63:3] == LED_ADDR[63:3]) begin
            led_m = data[LED_WIDTH-1:0];
        end
    endtask

    task automatic disp_op();
        logic [63:0] base;
        case (int'(rand_bits(3)))
            0, 1:    base = SEG_ADDR;
            2, 3:    base = LED_ADDR;
            4:       base = SWT_ADDR;
            5:       base = KBD_ADDR;
            6:       base = RTC_ADDR;
            default: base = 64'ha000_00a0;  // Nothing mapped here
        endcase
        disp_write(base + rand_bits(3), rand_bits(64));
    endtask

    task automatic kbd_op(input logic push, input logic do_read);
        logic [7:0]  code;
        logic [63:0] exp;
        start_cycle();
        code     = 8'(rand_bits(8));
        kb_valid = push;
        kb_code  = code;
        if (do_read) begin
            exp = '0;
            if (kb_q.size() > 0) begin
                exp = 64'(kb_q.pop_front());
            end
            issue_read(KBD_ADDR + rand_bits(3), pick_width());
            check_value("rdata", rdata, exp);
        end
        if (push && kb_q.size() < KB_DEPTH) begin
            kb_q.push_back(code);       // A full queue drops the code
        end
    endtask

    task automatic swt_op();
        logic [3:0] sel;
        start_cycle();
        swt = 8'(rand_bits(8));
        sel = 4'(rand_bits(4));
        if (sel == 4'd15) begin
            req.raddr = RAM_BASE;       // ren stays low
            #1;
            check_value("rdata", rdata, '0);
        end else if (sel[3]) begin
            issue_read(SWT_ADDR + 64'(sel[2:0]), pick_width());
            check_value("rdata", rdata, {56'd0, swt});
        end else begin
            issue_read(UNMAPPED[sel[2:0]], pick_width());
            check_value("rdata", rdata, '0);
        end
    endtask

    task automatic rtc_read();
        start_cycle();
        issue_read(RTC_ADDR + rand_bits(3), pick_width());
        check_value("rdata", rdata, edges / 64'(RTC_DIV));
    endtask

    task automatic check_zero_state();
        start_cycle();
        check_value("seg", 64'(seg), '0);
        check_value("led", 64'(led), '0);
        issue_read(RTC_ADDR, W_D);
        check_value("rdata", rdata, '0);
        start_cycle();
        issue_read(KBD_ADDR, W_D);
        check_value("rdata", rdata, '0);
    endtask

    initial begin
        lfsr     = 16'd50;
        rst_n    = 1'b0;
        req      = '0;
        kb_code  = '0;
        kb_valid = 1'b0;
        swt      = '0;
        seg_m    = '0;
        led_m    = '0;
        checks   = 0;
        errors   = 0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        check_zero_state();

        // Known contents everywhere before random loads
        for (int i = 0; i < RAM_WORDS; i++) begin
            start_cycle();
            req.wen      = 1'b1;
            req.waddr    = RAM_BASE + (64'(i) << 3);
            req.wwidth   = W_D;
            req.wdata    = rand_bits(64);
            ram_m[9'(i)] = req.wdata;
        end
        repeat (N_RAM) ram_op();
        repeat (N_DISP) disp_op();

        // RAM words whose low address bits match the peripheral windows
        for (int i = 8; i < 24; i++) begin
            start_cycle();
            issue_read(RAM_BASE + (64'(i) << 3), W_D);
            check_value("rdata", rdata, ram_m[9'(i)]);
        end

        kbd_op(1'b0, 1'b1);
        repeat (KB_DEPTH + 3) kbd_op(1'b1, 1'b0);  // Overflows the FIFO
        repeat (KB_DEPTH + 1) kbd_op(1'b0, 1'b1);
        repeat (N_KBD) kbd_op(1'(rand_bits(1)), 1'(rand_bits(1)));
        repeat (KB_DEPTH + 1) kbd_op(1'b0, 1'b1);

        repeat (N_SWT) swt_op();
        repeat (N_RTC) begin
            repeat (int'(rand_bits(2))) start_cycle();
            rtc_read();
        end

        disp_write(SEG_ADDR, '1);
        disp_write(LED_ADDR, '1);
        repeat (3) kbd_op(1'b1, 1'b0);
        @(negedge clk);
        rst_n    = 1'b0;
        req      = '0;
        kb_valid = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        seg_m = '0;
        led_m = '0;
        kb_q.delete();
        check_zero_state();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== build.f ====
hw/mmio_pkg.sv
hw/data_ram.sv
hw/kbd_fifo.sv
hw/rtc_timer.sv
hw/mmio.sv
hw/mmio_top.sv
tests/mmio_sva.sv
tests/tb_mmio.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_mmio -f build.f -o vsim

# Keep going on a non-zero exit so the log can be inspected
status=0
./obj_dir/vsim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "PASS: all tests" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"
